/* verilog/scope_pkg.sv */
/*
 * scope datapath types
 * sample strobe, trigger source and acquisition state encodings,
 * and the configuration word that the register bank drives
 */

package scope_pkg;

  // sample path width
  localparam int SMP_W  = 14;

  // configuration field widths
  localparam int DECF_W = 17;  // decimation factor
  localparam int SHR_W  = 4;   // averaging right shift
  localparam int DLY_W  = 16;  // post trigger delay

  // one sample with its strobe
  typedef struct packed {
    logic signed [SMP_W-1:0] dat;
    logic                    vld;  // single cycle
  } smp_t;

  // trigger source select
  typedef enum logic [1:0] {
    TRG_SW  = 2'd0,  // software strobe
    TRG_PDG = 2'd1,  // positive edge
    TRG_NDG = 2'd2,  // negative edge
    TRG_EXT = 2'd3   // external pin
  } trg_src_e;

  typedef enum logic [1:0] {
    ACQ_IDLE  = 2'd0,
    ACQ_ARMED = 2'd1,  // pre trigger capture
    ACQ_POST  = 2'd2   // counting down delay
  } acq_state_e;

  typedef struct packed {
    logic                    avg;  // averaging enable
    logic [DECF_W-1:0]       dec;  // samples per output, 0 acts as 1
    logic [SHR_W-1:0]        shr;
    logic signed [SMP_W-1:0] lvl;  // trigger level
    logic [SMP_W-1:0]        hst;  // hysteresis
    trg_src_e                src;
    logic [DLY_W-1:0]        dly;  // decimated samples after trigger
  } cfg_t;

endpackage

/* verilog/scope_bus_pkg.sv */
/*
 * system bus types for the scope
 * request and response words plus register offsets and buffer window
 */

package scope_bus_pkg;

  typedef struct packed {
    logic [31:0] addr;
    logic [31:0] wdata;
    logic        wen;   // write strobe
    logic        ren;   // read strobe
  } sys_req_t;

  typedef struct packed {
    logic [31:0] rdata;
    logic        ack;
    logic        err;   // unmapped access
  } sys_rsp_t;

  // register offsets, low 6 address bits
  typedef enum logic [5:0] {
    REG_CTL = 6'h00,  // rst/trg/arm strobes
    REG_STS = 6'h04,  // acquisition state
    REG_SRC = 6'h08,
    REG_DLY = 6'h0c,
    REG_LVL = 6'h10,
    REG_HST = 6'h14,
    REG_AVG = 6'h24,
    REG_DEC = 6'h28,
    REG_SHR = 6'h2c,
    REG_PTR = 6'h30   // {wr_ptr, trg_ptr}
  } reg_addr_e;

  localparam logic [31:0] BUF_BASE = 32'h1000;  // capture buffer window

endpackage

/* verilog/scope_regs.sv */
/*
 * scope register bank
 * config registers, control strobes, status readback,
 * and buffer window reads forwarded to the capture RAM
 */

`timescale 1ns/1ns

module scope_regs #(
  parameter int BUF_AW = 10
) (
  input  logic                              clk,
  input  logic                              rstn,
  input  scope_bus_pkg::sys_req_t           sys_req,
  output scope_bus_pkg::sys_rsp_t           sys_rsp,
  output scope_pkg::cfg_t                   cfg,
  output logic                              ctl_rst,  // datapath clear
  output logic                              ctl_trg,  // software trigger
  output logic                              ctl_arm,
  input  scope_pkg::acq_state_e             sts_state,
  input  logic [BUF_AW-1:0]                 trg_ptr,
  input  logic [BUF_AW-1:0]                 wr_ptr,
  output logic                              rd_req,
  output logic [BUF_AW-1:0]                 rd_addr,
  input  logic                              rd_vld,
  input  logic signed [scope_pkg::SMP_W-1:0] rd_dat
);

  localparam int SMP_W = scope_pkg::SMP_W;

  logic [31:0] buf_off;    // offset into buffer window
  logic        buf_hit;
  logic        reg_hit;
  logic [31:0] reg_rdata;
  logic        buf_pend;   // waiting on capture RAM

  ////////////////////////////////////////
  // address decode
  ////////////////////////////////////////

  assign buf_off = sys_req.addr - scope_bus_pkg::BUF_BASE;  // wraps high below base
  assign buf_hit = (buf_off >> (BUF_AW + 2)) == 32'd0;      // word addressed, depth words

  assign rd_req  = sys_req.ren & buf_hit;
  assign rd_addr = buf_off[BUF_AW+1:2];

  always_comb begin
    reg_hit   = (sys_req.addr[31:6] == 26'd0);
    reg_rdata = 32'd0;
    case (sys_req.addr[5:0])
      scope_bus_pkg::REG_CTL: reg_rdata = 32'd0;  // strobes only
      scope_bus_pkg::REG_STS: reg_rdata = 32'(sts_state);
      scope_bus_pkg::REG_SRC: reg_rdata = 32'(cfg.src);
      scope_bus_pkg::REG_DLY: reg_rdata = 32'(cfg.dly);
      scope_bus_pkg::REG_LVL: reg_rdata = {{(32-SMP_W){1'b0}}, cfg.lvl};  // masked, no sign
      scope_bus_pkg::REG_HST: reg_rdata = 32'(cfg.hst);
      scope_bus_pkg::REG_AVG: reg_rdata = 32'(cfg.avg);
      scope_bus_pkg::REG_DEC: reg_rdata = 32'(cfg.dec);
      scope_bus_pkg::REG_SHR: reg_rdata = 32'(cfg.shr);
      scope_bus_pkg::REG_PTR: reg_rdata = {16'(wr_ptr), 16'(trg_ptr)};
      default:                reg_hit   = 1'b0;
    endcase
  end

  ////////////////////////////////////////
  // bus response and register writes
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      sys_rsp  <= '0;
      cfg      <= '0;
      ctl_rst  <= 1'b0;
      ctl_trg  <= 1'b0;
      ctl_arm  <= 1'b0;
      buf_pend <= 1'b0;
    end else begin
      sys_rsp.ack <= 1'b0;
      sys_rsp.err <= 1'b0;
      ctl_rst     <= 1'b0;  // strobes last one cycle
      ctl_trg     <= 1'b0;
      ctl_arm     <= 1'b0;
      // buffer data back, ack next cycle
      if (buf_pend && rd_vld) begin
        sys_rsp.ack   <= 1'b1;
        sys_rsp.rdata <= {{(32-SMP_W){rd_dat[SMP_W-1]}}, rd_dat};
        buf_pend      <= 1'b0;
      end
      if (sys_req.wen) begin
        sys_rsp.ack <= 1'b1;
        sys_rsp.err <= !reg_hit && !buf_hit;  // buffer window writes dropped
        if (reg_hit) begin
          case (sys_req.addr[5:0])
            scope_bus_pkg::REG_CTL: begin
              ctl_rst <= sys_req.wdata[0];
              ctl_trg <= sys_req.wdata[1];
              ctl_arm <= sys_req.wdata[2];
            end
            scope_bus_pkg::REG_SRC: cfg.src <= scope_pkg::trg_src_e'(sys_req.wdata[1:0]);
            scope_bus_pkg::REG_DLY: cfg.dly <= sys_req.wdata[scope_pkg::DLY_W-1:0];
            scope_bus_pkg::REG_LVL: cfg.lvl <= sys_req.wdata[SMP_W-1:0];
            scope_bus_pkg::REG_HST: cfg.hst <= sys_req.wdata[SMP_W-1:0];
            scope_bus_pkg::REG_AVG: cfg.avg <= sys_req.wdata[0];
            scope_bus_pkg::REG_DEC: cfg.dec <= sys_req.wdata[scope_pkg::DECF_W-1:0];
            scope_bus_pkg::REG_SHR: cfg.shr <= sys_req.wdata[scope_pkg::SHR_W-1:0];
            default: ;  // STS and PTR read only
          endcase
        end
      end else if (sys_req.ren) begin
        if (buf_hit) begin
          buf_pend <= 1'b1;  // ack held until rd_vld
        end else begin
          sys_rsp.ack   <= 1'b1;
          sys_rsp.err   <= !reg_hit;
          sys_rsp.rdata <= reg_rdata;
        end
      end
    end
  end

endmodule

/* verilog/scope_dec_avg.sv */
/*
 * decimator with optional averaging
 * sums each group of dec samples, emits the shifted sum or the last sample
 */

`timescale 1ns/1ns

module scope_dec_avg #(
  parameter int DEC_W = 17
) (
  input  logic             clk,
  input  logic             rstn,
  input  logic             ctl_rst,  // restart group
  input  scope_pkg::cfg_t  cfg,
  input  scope_pkg::smp_t  smp_in,
  output scope_pkg::smp_t  smp_dec
);

  localparam int SMP_W = scope_pkg::SMP_W;
  localparam int ACC_W = SMP_W + DEC_W;  // full group sum, no overflow

  logic [DEC_W-1:0]        cnt;       // samples taken in current group
  logic [DEC_W-1:0]        dec_lim;
  logic                    last;      // this sample closes the group
  logic signed [ACC_W-1:0] sum;
  logic signed [ACC_W-1:0] sum_nxt;
  logic signed [ACC_W-1:0] sum_shr;
  logic                    vld_q;
  logic signed [SMP_W-1:0] dat_q;

  assign dec_lim = (cfg.dec == '0) ? DEC_W'(1) : DEC_W'(cfg.dec);  // 0 acts as 1
  assign last    = (cnt >= dec_lim - 1'b1);    // >= survives a lowered dec
  assign sum_nxt = ((cnt == '0) ? '0 : sum) + ACC_W'(smp_in.dat);
  assign sum_shr = sum_nxt >>> cfg.shr;

  ////////////////////////////////////////
  // group counter and strobe
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn || ctl_rst) begin
      cnt   <= '0;
      vld_q <= 1'b0;
    end else begin
      vld_q <= smp_in.vld & last;
      if (smp_in.vld) begin
        cnt <= last ? '0 : cnt + 1'b1;
      end
    end
  end

  // accumulator and output word
  always_ff @(posedge clk) begin
    if (smp_in.vld) begin
      sum <= sum_nxt;
      if (last) begin
        dat_q <= cfg.avg ? sum_shr[SMP_W-1:0] : smp_in.dat;  // truncate
      end
    end
  end

  assign smp_dec = '{dat: dat_q, vld: vld_q};

endmodule

/* verilog/scope_edge.sv */
/*
 * schmitt edge detector
 * arm below lvl-hst then fire at lvl for positive, mirrored for negative
 */

`timescale 1ns/1ns

module scope_edge (
  input  logic            clk,
  input  logic            rstn,
  input  scope_pkg::cfg_t cfg,
  input  scope_pkg::smp_t smp_in,
  output logic            trg_pdg,  // one cycle pulse
  output logic            trg_ndg
);

  localparam int CMP_W = scope_pkg::SMP_W + 2;  // room for lvl +/- hst

  logic signed [CMP_W-1:0] dat_x;
  logic signed [CMP_W-1:0] lvl_x;
  logic signed [CMP_W-1:0] thr_lo;  // lvl - hst
  logic signed [CMP_W-1:0] thr_hi;  // lvl + hst
  logic                    pos_arm;
  logic                    neg_arm;

  assign dat_x  = CMP_W'(smp_in.dat);
  assign lvl_x  = CMP_W'(cfg.lvl);
  assign thr_lo = lvl_x - $signed({2'b00, cfg.hst});
  assign thr_hi = lvl_x + $signed({2'b00, cfg.hst});

  always_ff @(posedge clk) begin
    if (!rstn) begin
      pos_arm <= 1'b0;
      neg_arm <= 1'b0;
      trg_pdg <= 1'b0;
      trg_ndg <= 1'b0;
    end else begin
      trg_pdg <= smp_in.vld & pos_arm & (dat_x >= lvl_x);
      trg_ndg <= smp_in.vld & neg_arm & (dat_x <= lvl_x);
      if (smp_in.vld) begin
        // positive: arm low, release at level
        if (dat_x < thr_lo)       pos_arm <= 1'b1;
        else if (dat_x >= lvl_x)  pos_arm <= 1'b0;
        // negative mirror
        if (dat_x > thr_hi)       neg_arm <= 1'b1;
        else if (dat_x <= lvl_x)  neg_arm <= 1'b0;
      end
    end
  end

endmodule

/* verilog/scope_acq.sv */
/*
 * acquisition control
 * arm, trigger select and post trigger delay, drives the buffer write port
 */

`timescale 1ns/1ns

module scope_acq #(
  parameter int BUF_AW = 10
) (
  input  logic                               clk,
  input  logic                               rstn,
  input  logic                               ctl_rst,
  input  logic                               ctl_arm,
  input  logic                               ctl_trg,
  input  logic                               trg_pdg,
  input  logic                               trg_ndg,
  input  logic                               trg_ext,
  input  scope_pkg::cfg_t                    cfg,
  input  scope_pkg::smp_t                    smp_dec,
  output scope_pkg::acq_state_e              sts_state,
  output logic [BUF_AW-1:0]                  trg_ptr,
  output logic [BUF_AW-1:0]                  wr_ptr,
  output logic                               wr_en,
  output logic [BUF_AW-1:0]                  wr_addr,
  output logic signed [scope_pkg::SMP_W-1:0] wr_dat
);

  scope_pkg::acq_state_e         state;
  logic [scope_pkg::DLY_W-1:0]   dly_cnt;  // writes left after trigger
  logic [BUF_AW-1:0]             wr_ptr_nxt;
  logic                          trg_hit;

  // trigger mux
  always_comb begin
    case (cfg.src)
      scope_pkg::TRG_SW:  trg_hit = ctl_trg;
      scope_pkg::TRG_PDG: trg_hit = trg_pdg;
      scope_pkg::TRG_NDG: trg_hit = trg_ndg;
      default:            trg_hit = trg_ext;
    endcase
  end

  // capture while armed, and in POST until the delay runs out
  assign wr_en = smp_dec.vld & ((state == scope_pkg::ACQ_ARMED) |
                 ((state == scope_pkg::ACQ_POST) & (dly_cnt != '0)));
  assign wr_addr    = wr_ptr;
  assign wr_dat     = smp_dec.dat;
  assign wr_ptr_nxt = wr_ptr + {{(BUF_AW-1){1'b0}}, wr_en};  // wraps at depth
  assign sts_state  = state;

  ////////////////////////////////////////
  // state machine
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state   <= scope_pkg::ACQ_IDLE;
      wr_ptr  <= '0;
      trg_ptr <= '0;
      dly_cnt <= '0;
    end else if (ctl_rst) begin
      state <= scope_pkg::ACQ_IDLE;
    end else begin
      wr_ptr <= wr_ptr_nxt;
      case (state)
        scope_pkg::ACQ_IDLE: if (ctl_arm) begin
          state  <= scope_pkg::ACQ_ARMED;
          wr_ptr <= '0;
        end
        scope_pkg::ACQ_ARMED: if (trg_hit) begin
          state   <= scope_pkg::ACQ_POST;
          trg_ptr <= wr_ptr_nxt;  // first sample after the trigger
          dly_cnt <= cfg.dly;
        end
        scope_pkg::ACQ_POST: begin
          if (dly_cnt == '0) begin
            state <= scope_pkg::ACQ_IDLE;  // dly of 0
          end else if (wr_en) begin
            dly_cnt <= dly_cnt - 1'b1;
            if (dly_cnt == scope_pkg::DLY_W'(1)) state <= scope_pkg::ACQ_IDLE;
          end
        end
        default: state <= scope_pkg::ACQ_IDLE;
      endcase
    end
  end

endmodule

/* verilog/scope_buf.sv */
/*
 * capture buffer
 * single port RAM, capture writes win, bus reads wait for a free cycle
 */

`timescale 1ns/1ns

module scope_buf #(
  parameter int BUF_AW = 10
) (
  input  logic                               clk,
  input  logic                               wr_en,
  input  logic [BUF_AW-1:0]                  wr_addr,
  input  logic signed [scope_pkg::SMP_W-1:0] wr_dat,
  input  logic                               rd_req,   // strobe
  input  logic [BUF_AW-1:0]                  rd_addr,
  output logic                               rd_vld,
  output logic signed [scope_pkg::SMP_W-1:0] rd_dat
);

  localparam int DEPTH = 1 << BUF_AW;

  logic signed [scope_pkg::SMP_W-1:0] mem [DEPTH];

  logic              pend;       // read held off by a write
  logic [BUF_AW-1:0] pend_addr;
  logic              req_live;
  logic              grant;
  logic [BUF_AW-1:0] rd_a;

  ////////////////////////////////////////
  // arbiter
  ////////////////////////////////////////

  assign req_live = rd_req | pend;
  assign grant    = req_live & ~wr_en;  // write has priority
  assign rd_a     = rd_req ? rd_addr : pend_addr;

  // settles low once wr_en and rd_req are idle
  always_ff @(posedge clk) begin
    pend   <= req_live & wr_en;
    rd_vld <= grant;
    if (rd_req) pend_addr <= rd_addr;
  end

  // one access per cycle
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_dat;
    end else if (grant) begin
      rd_dat <= mem[rd_a];
    end
  end

endmodule

/* verilog/scope_top.sv */
/*
 * oscilloscope capture top
 * registers, decimator, edge trigger, acquisition control and buffer
 */

`timescale 1ns/1ns

module scope_top #(
  parameter int DEC_W  = 17,
  parameter int BUF_AW = 10
) (
  input  logic                    clk,
  input  logic                    rstn,
  input  scope_pkg::smp_t         smp_in,
  input  logic                    trg_ext,
  input  scope_bus_pkg::sys_req_t sys_req,
  output scope_bus_pkg::sys_rsp_t sys_rsp,
  output logic                    trg_pdg,  // edge pulses, also exported
  output logic                    trg_ndg
);

  scope_pkg::cfg_t                    cfg;
  scope_pkg::smp_t                    smp_dec;   // decimated stream
  scope_pkg::acq_state_e              sts_state;
  logic                               ctl_rst;
  logic                               ctl_trg;
  logic                               ctl_arm;
  logic [BUF_AW-1:0]                  trg_ptr;
  logic [BUF_AW-1:0]                  wr_ptr;
  // buffer ports
  logic                               wr_en;
  logic [BUF_AW-1:0]                  wr_addr;
  logic signed [scope_pkg::SMP_W-1:0] wr_dat;
  logic                               rd_req;
  logic [BUF_AW-1:0]                  rd_addr;
  logic                               rd_vld;
  logic signed [scope_pkg::SMP_W-1:0] rd_dat;

  ////////////////////////////////////////
  // instances
  ////////////////////////////////////////

  scope_regs #(.BUF_AW(BUF_AW)) u_regs (
    .clk, .rstn, .sys_req, .sys_rsp, .cfg,
    .ctl_rst, .ctl_trg, .ctl_arm,
    .sts_state, .trg_ptr, .wr_ptr,
    .rd_req, .rd_addr, .rd_vld, .rd_dat
  );

  scope_dec_avg #(.DEC_W(DEC_W)) u_dec_avg (
    .clk, .rstn, .ctl_rst, .cfg, .smp_in, .smp_dec
  );

  scope_edge u_edge (
    .clk, .rstn, .cfg, .smp_in, .trg_pdg, .trg_ndg
  );

  scope_acq #(.BUF_AW(BUF_AW)) u_acq (
    .clk, .rstn, .ctl_rst, .ctl_arm, .ctl_trg,
    .trg_pdg, .trg_ndg, .trg_ext, .cfg, .smp_dec,
    .sts_state, .trg_ptr, .wr_ptr, .wr_en, .wr_addr, .wr_dat
  );

  scope_buf #(.BUF_AW(BUF_AW)) u_buf (
    .clk, .wr_en, .wr_addr, .wr_dat,
    .rd_req, .rd_addr, .rd_vld, .rd_dat
  );

endmodule

/* tests/scope_tb.sv */
/*
 * scope capture testbench
 * register access, decimation, averaging, edge trigger, live buffer reads, clear
 */

`timescale 1ns/1ns

module scope_tb;

  localparam int BUF_AW  = 6;
  localparam int DEPTH   = 1 << BUF_AW;
  localparam int SMP_W   = scope_pkg::SMP_W;
  localparam int RST_CYC = 8;

  // stimulus lengths, also size the watchdog
  localparam int N_PRE   = 16;   // samples before the software trigger
  localparam int N_POST  = 32;
  localparam int N_EDGE  = 20;
  localparam int N_LIVE  = 48;   // stays below DEPTH, no wrap
  localparam int N_CLR   = 16;
  localparam int N_BUS   = 100;  // bus transfers, about 4 cycles each
  localparam int STIM_CYC = RST_CYC + 2 * (N_PRE + N_POST) + N_EDGE + 2 * N_LIVE
                            + N_CLR + 4 * N_BUS;

  logic                    clk;
  logic                    rstn;
  scope_pkg::smp_t         smp_in;
  logic                    trg_ext;
  scope_bus_pkg::sys_req_t sys_req;
  scope_bus_pkg::sys_rsp_t sys_rsp;
  logic                    trg_pdg;
  logic                    trg_ndg;

  logic [31:0]             seed = 32'h2237;
  logic signed [SMP_W-1:0] smp_log [0:255];  // valid samples since last clear of n_log
  int                      n_log;
  int                      first_pdg;        // log index of first predicted pdg
  // edge model state
  int                      sh_lvl;
  int                      sh_hst;
  logic                    m_pos;
  logic                    m_neg;
  logic                    exp_pdg;
  logic                    exp_ndg;

  scope_top #(.DEC_W(17), .BUF_AW(BUF_AW)) u_dut (
    .clk, .rstn, .smp_in, .trg_ext, .sys_req, .sys_rsp, .trg_pdg, .trg_ndg
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  ////////////////////////////////////////
  // checks
  ////////////////////////////////////////

  task automatic fail_stop(input string msg);
    $display("%s", msg);
    $display("Simulation finished: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp)
      fail_stop($sformatf("Fail %s: expected %08h, actual %08h", name, exp, act));
  endtask

  // buffer words come back sign extended
  task automatic check_smp(input string name, input logic signed [SMP_W-1:0] exp,
                           input logic [31:0] act);
    if (act !== {{(32-SMP_W){exp[SMP_W-1]}}, exp})
      fail_stop($sformatf("Fail %s: expected %0d, actual %0d", name, exp, $signed(act)));
  endtask

  task automatic check_state(input string name, input scope_pkg::acq_state_e exp,
                             input scope_pkg::acq_state_e act);
    if (act !== exp)
      fail_stop($sformatf("Fail %s: expected %0d (%s), actual %0d (%s)",
                          name, exp, exp.name(), act, act.name()));
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp)
      fail_stop($sformatf("Fail %s: expected %b, actual %b", name, exp, act));
  endtask

  ////////////////////////////////////////
  // reference model
  ////////////////////////////////////////

  function automatic logic [31:0] lcg(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // k-th decimated output of the logged samples
  function automatic logic signed [SMP_W-1:0] dec_ref(input int k, input int dec,
                                                       input bit avg, input int shr);
    int sum;
    sum = 0;
    for (int j = 0; j < dec; j++) sum += smp_log[k*dec + j];
    if (!avg) return smp_log[k*dec + dec - 1];  // closing sample
    sum = sum >>> shr;
    return sum[SMP_W-1:0];  // truncate
  endfunction

  // schmitt rule, pulses land one cycle after the sample
  task automatic edge_model(input logic vld, input logic signed [SMP_W-1:0] dat);
    int d;
    d = dat;
    exp_pdg = vld && m_pos && (d >= sh_lvl);
    exp_ndg = vld && m_neg && (d <= sh_lvl);
    if (vld) begin
      if (d < sh_lvl - sh_hst) m_pos = 1'b1;
      else if (d >= sh_lvl)    m_pos = 1'b0;
      if (d > sh_lvl + sh_hst) m_neg = 1'b1;
      else if (d <= sh_lvl)    m_neg = 1'b0;
    end
  endtask

  // edge pulse compare, expected value taken at the edge
  initial begin
    logic want_p;
    logic want_n;
    wait (rstn === 1'b1);
    forever begin
      @(posedge clk);
      want_p = exp_pdg;
      want_n = exp_ndg;
      #2;
      check_bit("edge trg_pdg", want_p, trg_pdg);
      check_bit("edge trg_ndg", want_n, trg_ndg);
    end
  end

  ////////////////////////////////////////
  // drivers
  ////////////////////////////////////////

  task automatic drive_cycle(input logic vld, input logic signed [SMP_W-1:0] dat);
    @(posedge clk);
    #1;
    smp_in = '{dat: dat, vld: vld};
    edge_model(vld, dat);
    if (vld) begin
      if (exp_pdg && first_pdg < 0) first_pdg = n_log;
      smp_log[n_log] = dat;
      n_log++;
    end
  endtask

  // random samples, sparse puts idle cycles in between
  task automatic stream(input int n, input bit sparse);
    for (int i = 0; i < n; i++) begin
      seed = lcg(seed);
      if (sparse && seed[31]) drive_cycle(1'b0, '0);
      drive_cycle(1'b1, seed[29:16]);
    end
    drive_cycle(1'b0, '0);
  endtask

  task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
    logic signed [SMP_W-1:0] lvl_t;
    @(posedge clk);
    #1;
    sys_req = '{addr: addr, wdata: data, wen: 1'b1, ren: 1'b0};
    @(posedge clk);
    #1;
    sys_req.wen = 1'b0;
    while (!sys_rsp.ack) begin
      @(posedge clk);
      #1;
    end
    lvl_t = data[SMP_W-1:0];
    if (addr == 32'(scope_bus_pkg::REG_LVL)) sh_lvl = lvl_t;  // mirror for edge model
    if (addr == 32'(scope_bus_pkg::REG_HST)) sh_hst = data[SMP_W-1:0];
  endtask

  task automatic bus_read(input logic [31:0] addr, output logic [31:0] data,
                          output logic err);
    @(posedge clk);
    #1;
    sys_req = '{addr: addr, wdata: 32'd0, wen: 1'b0, ren: 1'b1};
    @(posedge clk);
    #1;
    sys_req.ren = 1'b0;
    while (!sys_rsp.ack) begin  // buffer reads wait for a grant
      @(posedge clk);
      #1;
    end
    data = sys_rsp.rdata;
    err  = sys_rsp.err;
  endtask

  ////////////////////////////////////////
  // tests
  ////////////////////////////////////////

  task automatic reg_rw(input string name, input scope_bus_pkg::reg_addr_e ra,
                        input logic [31:0] wdata, input logic [31:0] mask);
    logic [31:0] rd;
    logic        err;
    bus_write(32'(ra), wdata);
    bus_read(32'(ra), rd, err);
    check_word(name, wdata & mask, rd);
    check_word({name, " err"}, 32'd0, 32'(err));
  endtask

  task automatic run_regs();
    logic [31:0] rd;
    logic        err;
    reg_rw("regs src", scope_bus_pkg::REG_SRC, 32'hffff_fff3, 32'h3);
    reg_rw("regs dly", scope_bus_pkg::REG_DLY, 32'h1234_5678, 32'hffff);
    reg_rw("regs lvl", scope_bus_pkg::REG_LVL, 32'hffff_ffff, 32'h3fff);
    reg_rw("regs hst", scope_bus_pkg::REG_HST, 32'h0000_abcd, 32'h3fff);
    reg_rw("regs avg", scope_bus_pkg::REG_AVG, 32'h0000_0003, 32'h1);
    reg_rw("regs dec", scope_bus_pkg::REG_DEC, 32'hfffe_0005, 32'h1_ffff);
    reg_rw("regs shr", scope_bus_pkg::REG_SHR, 32'h0000_001f, 32'hf);
    bus_read(32'h3c, rd, err);  // hole in the map
    check_word("regs unmapped err", 32'd1, 32'(err));
    bus_read(scope_bus_pkg::BUF_BASE + DEPTH * 4, rd, err);  // past buffer end
    check_word("regs buffer end err", 32'd1, 32'(err));
  endtask

  // software trigger capture, dec 4
  task automatic run_capture(input string name, input bit avg, input int shr);
    logic [31:0] rd;
    logic        err;
    int          tp;
    bus_write(32'(scope_bus_pkg::REG_DEC), 32'd4);
    bus_write(32'(scope_bus_pkg::REG_AVG), 32'(avg));
    bus_write(32'(scope_bus_pkg::REG_SHR), 32'(shr));
    bus_write(32'(scope_bus_pkg::REG_SRC), 32'(scope_pkg::TRG_SW));
    bus_write(32'(scope_bus_pkg::REG_DLY), 32'd8);
    bus_write(32'(scope_bus_pkg::REG_CTL), 32'h1);  // group restart
    bus_write(32'(scope_bus_pkg::REG_CTL), 32'h4);  // arm
    n_log = 0;
    stream(N_PRE, 1'b0);
    bus_write(32'(scope_bus_pkg::REG_CTL), 32'h2);  // trigger
    n_log = 0;
    stream(N_POST, 1'b0);
    bus_read(32'(scope_bus_pkg::REG_STS), rd, err);
    check_state({name, " state"}, scope_pkg::ACQ_IDLE, scope_pkg::acq_state_e'(rd[1:0]));
    bus_read(32'(scope_bus_pkg::REG_PTR), rd, err);
    tp = rd[15:0];
    check_word({name, " trg_ptr"}, N_PRE / 4, 32'(rd[15:0]));
    for (int k = 0; k < 8; k++) begin
      bus_read(scope_bus_pkg::BUF_BASE + ((tp + k) % DEPTH) * 4, rd, err);
      check_smp($sformatf("%s buf %0d", name, k), dec_ref(k, 4, avg, shr), rd);
    end
  endtask

  task automatic run_edge();
    logic [31:0] rd;
    logic        err;
    int          tp;
    bus_write(32'(scope_bus_pkg::REG_DEC), 32'd1);
    bus_write(32'(scope_bus_pkg::REG_AVG), 32'd0);
    bus_write(32'(scope_bus_pkg::REG_LVL), 32'd100);
    bus_write(32'(scope_bus_pkg::REG_HST), 32'd50);   // arms below 50
    bus_write(32'(scope_bus_pkg::REG_SRC), 32'(scope_pkg::TRG_PDG));
    bus_write(32'(scope_bus_pkg::REG_DLY), 32'd4);
    bus_write(32'(scope_bus_pkg::REG_CTL), 32'h1);
    drive_cycle(1'b1, 14'sd300);  // high level drops any stale arm flag
    drive_cycle(1'b1, 14'sd300);
    drive_cycle(1'b0, '0);
    bus_write(32'(scope_bus_pkg::REG_CTL), 32'h4);
    n_log     = 0;
    first_pdg = -1;
    for (int v = 120; v >= 20; v -= 20) drive_cycle(1'b1, 14'(v));  // dip
    for (int v = 30; v <= 230; v += 20) drive_cycle(1'b1, 14'(v));  // rise through lvl
    drive_cycle(1'b0, '0);
    bus_read(32'(scope_bus_pkg::REG_STS), rd, err);
    check_state("edge state", scope_pkg::ACQ_IDLE, scope_pkg::acq_state_e'(rd[1:0]));
    bus_read(32'(scope_bus_pkg::REG_PTR), rd, err);
    tp = rd[15:0];
    bus_read(scope_bus_pkg::BUF_BASE + tp * 4, rd, err);
    check_smp("edge trg_ptr sample", smp_log[first_pdg + 1], rd);
  endtask

  // reads race capture writes for the RAM
  task automatic run_live();
    logic [31:0] rd;
    logic        err;
    int          a;
    bus_write(32'(scope_bus_pkg::REG_SRC), 32'(scope_pkg::TRG_SW));
    bus_write(32'(scope_bus_pkg::REG_CTL), 32'h1);
    bus_write(32'(scope_bus_pkg::REG_CTL), 32'h4);
    n_log = 0;
    fork
      stream(N_LIVE, 1'b1);
      begin
        for (int i = 0; i < 8; i++) begin
          a = 5 * i;
          while (n_log <= a + 2) @(posedge clk);  // slot already written
          bus_read(scope_bus_pkg::BUF_BASE + a * 4, rd, err);
          check_smp($sformatf("live buf %0d", a), smp_log[a], rd);
        end
      end
    join
  endtask

  task automatic run_clear();
    logic [31:0] rd;
    logic        err;
    bus_read(32'(scope_bus_pkg::REG_STS), rd, err);
    check_state("clear armed", scope_pkg::ACQ_ARMED, scope_pkg::acq_state_e'(rd[1:0]));
    bus_write(32'(scope_bus_pkg::REG_CTL), 32'h1);
    bus_read(32'(scope_bus_pkg::REG_STS), rd, err);
    check_state("clear state", scope_pkg::ACQ_IDLE, scope_pkg::acq_state_e'(rd[1:0]));
    bus_read(32'(scope_bus_pkg::REG_PTR), rd, err);
    check_word("clear wr_ptr", N_LIVE % DEPTH, rd >> 16);
    stream(N_CLR, 1'b0);
    bus_read(32'(scope_bus_pkg::REG_PTR), rd, err);
    check_word("clear wr_ptr hold", N_LIVE % DEPTH, rd >> 16);  // idle, no writes
  endtask

  ////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////

  initial begin
    #(20 * STIM_CYC * 10);
    fail_stop("timeout, the tests did not finish in time");
  end

  initial begin
    smp_in    = '0;
    trg_ext   = 1'b0;
    sys_req   = '0;
    rstn      = 1'b0;
    n_log     = 0;
    first_pdg = -1;
    sh_lvl    = 0;
    sh_hst    = 0;
    m_pos     = 1'b0;
    m_neg     = 1'b0;
    exp_pdg   = 1'b0;
    exp_ndg   = 1'b0;
    repeat (RST_CYC) @(posedge clk);
    #1;
    rstn = 1'b1;
    run_regs();
    run_capture("dec", 1'b0, 0);
    run_capture("avg", 1'b1, 2);
    run_edge();
    run_live();
    run_clear();
    repeat (4) @(posedge clk);
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

/* sources.f */
verilog/scope_pkg.sv
verilog/scope_bus_pkg.sv
verilog/scope_regs.sv
verilog/scope_dec_avg.sv
verilog/scope_edge.sv
verilog/scope_acq.sv
verilog/scope_buf.sv
verilog/scope_top.sv
tests/scope_tb.sv
